// ==== src/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_id_t;

    // Register reported on o_end_data
    localparam reg_id_t END_REG  = 5'd10;
    localparam addr_t   RESET_PC = 32'h0000_0000;

    // RV32I major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASSB
    } alu_op_t;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_src_t;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_MEMORY,
        ST_WRITEBACK,
        ST_HALT
    } state_t;

endpackage

`default_nettype wire

// ==== src/gpr.sv ====
`timescale 1ns/10ps
`default_nettype none

module gpr
    import cpu_pkg::*;
(
    input  logic    i_sys_clk,
    input  logic    i_arst_n,
    input  reg_id_t i_rs1_id,
    input  reg_id_t i_rs2_id,
    input  logic    i_wr_en,
    input  reg_id_t i_wr_id,
    input  word_t   i_wr_data,
    output word_t   o_rs1_data,
    output word_t   o_rs2_data,
    output word_t   o_end_data
);

    word_t regs [32];

    always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_id != 5'd0)) begin
            regs[i_wr_id] <= i_wr_data;
        end
    end

    // x0 never written, so reads of it stay zero
    assign o_rs1_data = regs[i_rs1_id];
    assign o_rs2_data = regs[i_rs2_id];
    assign o_end_data = regs[END_REG];

endmodule

`default_nettype wire

// ==== src/ifu.sv ====
`timescale 1ns/10ps
`default_nettype none

module ifu
    import cpu_pkg::*;
(
    input  logic  i_sys_clk,
    input  logic  i_arst_n,
    input  logic  i_pc_en,
    input  logic  i_jmp_en,
    input  addr_t i_jmp_pc,
    output addr_t o_pc
);

    addr_t pc_q;
    addr_t pc_next;

    // Taken branch or jump overrides the sequential address
    always_comb begin
        if (i_jmp_en) begin
            pc_next = i_jmp_pc;
        end else begin
            pc_next = pc_q + 32'd4;
        end
    end

    always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q <= RESET_PC;
        end else if (i_pc_en) begin
            pc_q <= pc_next;
        end
    end

    assign o_pc = pc_q;

endmodule

`default_nettype wire

// ==== src/idu.sv ====
`timescale 1ns/10ps
`default_nettype none

module idu
    import cpu_pkg::*;
(
    input  logic    i_sys_clk,
    input  logic    i_arst_n,
    input  logic    i_load_en,
    input  inst_t   i_inst,
    output reg_id_t o_rs1_id,
    output reg_id_t o_rs2_id,
    output reg_id_t o_rd_id,
    output word_t   o_imm,
    output alu_op_t o_alu_op,
    output logic    o_use_imm,
    output logic    o_branch,
    output logic    o_branch_ne,
    output logic    o_jal,
    output logic    o_mem_rd,
    output logic    o_mem_wr,
    output logic    o_reg_wr_en,
    output logic    o_end,
    output wb_src_t o_wb_src
);

    inst_t      inst_q;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            inst_q <= '0;
        end else if (i_load_en) begin
            inst_q <= i_inst;
        end
    end

    assign opcode   = inst_q[6:0];
    assign funct3   = inst_q[14:12];
    assign funct7   = inst_q[31:25];
    assign o_rd_id  = inst_q[11:7];
    assign o_rs1_id = inst_q[19:15];
    assign o_rs2_id = inst_q[24:20];

    always_comb begin
        o_imm       = '0;
        o_alu_op    = ALU_ADD;
        o_use_imm   = 1'b0;
        o_branch    = 1'b0;
        o_branch_ne = 1'b0;
        o_jal       = 1'b0;
        o_mem_rd    = 1'b0;
        o_mem_wr    = 1'b0;
        o_reg_wr_en = 1'b0;
        o_end       = 1'b0;
        o_wb_src    = WB_ALU;
        case (opcode)
            OPC_LUI: begin
                o_imm       = {inst_q[31:12], 12'h000};
                o_alu_op    = ALU_PASSB;
                o_use_imm   = 1'b1;
                o_reg_wr_en = 1'b1;
            end
            OPC_OPIMM: begin
                o_imm       = {{20{inst_q[31]}}, inst_q[31:20]};
                o_use_imm   = 1'b1;
                // ADDI only
                o_reg_wr_en = (funct3 == 3'b000);
            end
            OPC_OP: begin
                o_reg_wr_en = 1'b1;
                case (funct3)
                    3'b000:  o_alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b010:  o_alu_op = ALU_SLT;
                    3'b100:  o_alu_op = ALU_XOR;
                    3'b110:  o_alu_op = ALU_OR;
                    3'b111:  o_alu_op = ALU_AND;
                    default: o_reg_wr_en = 1'b0;
                endcase
            end
            OPC_LOAD: begin
                o_imm       = {{20{inst_q[31]}}, inst_q[31:20]};
                o_use_imm   = 1'b1;
                o_mem_rd    = 1'b1;
                o_reg_wr_en = 1'b1;
                o_wb_src    = WB_MEM;
            end
            OPC_STORE: begin
                o_imm     = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
                o_use_imm = 1'b1;
                o_mem_wr  = 1'b1;
            end
            OPC_BRANCH: begin
                o_imm       = {{19{inst_q[31]}}, inst_q[31], inst_q[7],
                               inst_q[30:25], inst_q[11:8], 1'b0};
                o_branch    = (funct3[2:1] == 2'b00);
                o_branch_ne = funct3[0];
            end
            OPC_JAL: begin
                o_imm       = {{11{inst_q[31]}}, inst_q[31], inst_q[19:12],
                               inst_q[20], inst_q[30:21], 1'b0};
                o_jal       = 1'b1;
                o_reg_wr_en = 1'b1;
                o_wb_src    = WB_PC4;
            end
            OPC_SYSTEM: begin
                // EBREAK has imm field 1
                o_end = (inst_q[31:20] == 12'h001) && (funct3 == 3'b000);
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/exu.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu
    import cpu_pkg::*;
(
    input  logic    i_sys_clk,
    input  logic    i_arst_n,
    input  logic    i_exe_en,
    input  addr_t   i_pc,
    input  word_t   i_rs1_data,
    input  word_t   i_rs2_data,
    input  word_t   i_imm,
    input  alu_op_t i_alu_op,
    input  logic    i_use_imm,
    input  logic    i_branch,
    input  logic    i_branch_ne,
    input  logic    i_jal,
    output word_t   o_res,
    output logic    o_jmp_en,
    output addr_t   o_jmp_pc
);

    word_t opb;
    word_t alu_res;
    logic  rs_eq;
    logic  taken;

    assign opb   = i_use_imm ? i_imm : i_rs2_data;
    assign rs_eq = (i_rs1_data == i_rs2_data);
    assign taken = i_jal | (i_branch & (i_branch_ne ? !rs_eq : rs_eq));

    always_comb begin
        case (i_alu_op)
            ALU_ADD:   alu_res = i_rs1_data + opb;
            ALU_SUB:   alu_res = i_rs1_data - opb;
            ALU_AND:   alu_res = i_rs1_data & opb;
            ALU_OR:    alu_res = i_rs1_data | opb;
            ALU_XOR:   alu_res = i_rs1_data ^ opb;
            ALU_SLT:   alu_res = {31'd0, $signed(i_rs1_data) < $signed(opb)};
            ALU_PASSB: alu_res = opb;
            default:   alu_res = '0;
        endcase
    end

    always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_res    <= '0;
            o_jmp_en <= 1'b0;
            o_jmp_pc <= '0;
        end else if (i_exe_en) begin
            o_res    <= alu_res;
            o_jmp_en <= taken;
            o_jmp_pc <= i_pc + i_imm;
        end
    end

endmodule

`default_nettype wire

// ==== src/lsu.sv ====
`timescale 1ns/10ps
`default_nettype none

module lsu
    import cpu_pkg::*;
(
    input  logic  i_sys_clk,
    input  logic  i_arst_n,
    input  logic  i_mem_en,
    input  logic  i_mem_rd,
    input  logic  i_mem_wr,
    input  word_t i_addr,
    input  word_t i_wr_data,
    input  word_t i_ram_rd_data,
    output logic  o_ram_rd_en,
    output addr_t o_ram_rd_addr,
    output logic  o_ram_wr_en,
    output addr_t o_ram_wr_addr,
    output word_t o_ram_wr_data,
    output word_t o_load_data
);

    // Requests only during the memory state
    assign o_ram_rd_en   = i_mem_en & i_mem_rd;
    assign o_ram_rd_addr = i_addr;
    assign o_ram_wr_en   = i_mem_en & i_mem_wr;
    assign o_ram_wr_addr = i_addr;
    assign o_ram_wr_data = i_wr_data;

    always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_load_data <= '0;
        end else if (o_ram_rd_en) begin
            o_load_data <= i_ram_rd_data;
        end
    end

endmodule

`default_nettype wire

// ==== src/cpu.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu
    import cpu_pkg::*;
(
    input  logic  i_sys_clk,
    input  logic  i_arst_n,
    input  inst_t i_rom_rd_data,
    output addr_t o_rom_rd_addr,
    input  word_t i_ram_rd_data,
    output logic  o_ram_rd_en,
    output addr_t o_ram_rd_addr,
    output logic  o_ram_wr_en,
    output addr_t o_ram_wr_addr,
    output word_t o_ram_wr_data,
    output logic  o_end_flag,
    output word_t o_end_data
);

    state_t  state_q;
    state_t  state_next;

    addr_t   w_pc;
    word_t   w_rs1_data;
    word_t   w_rs2_data;
    reg_id_t w_rs1_id;
    reg_id_t w_rs2_id;
    reg_id_t w_rd_id;
    word_t   w_imm;
    alu_op_t w_alu_op;
    logic    w_use_imm;
    logic    w_branch;
    logic    w_branch_ne;
    logic    w_jal;
    logic    w_mem_rd;
    logic    w_mem_wr;
    logic    w_reg_wr_en;
    logic    w_end;
    wb_src_t w_wb_src;
    word_t   w_exu_res;
    logic    w_jmp_en;
    addr_t   w_jmp_pc;
    word_t   w_load_data;
    word_t   w_wb_data;
    logic    w_in_wb;

    // One instruction at a time, five cycles each
    always_comb begin
        case (state_q)
            ST_FETCH:     state_next = ST_DECODE;
            ST_DECODE:    state_next = ST_EXECUTE;
            ST_EXECUTE:   state_next = ST_MEMORY;
            ST_MEMORY:    state_next = ST_WRITEBACK;
            ST_WRITEBACK: state_next = w_end ? ST_HALT : ST_FETCH;
            default:      state_next = ST_HALT;
        endcase
    end

    always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q    <= ST_FETCH;
            o_end_flag <= 1'b0;
        end else begin
            state_q <= state_next;
            if (w_in_wb && w_end) begin
                o_end_flag <= 1'b1;
            end
        end
    end

    assign w_in_wb       = (state_q == ST_WRITEBACK);
    assign o_rom_rd_addr = w_pc;

    always_comb begin
        case (w_wb_src)
            WB_MEM:  w_wb_data = w_load_data;
            WB_PC4:  w_wb_data = w_pc + 32'd4;
            default: w_wb_data = w_exu_res;
        endcase
    end

    gpr u_gpr (
        .i_sys_clk (i_sys_clk),
        .i_arst_n  (i_arst_n),
        .i_rs1_id  (w_rs1_id),
        .i_rs2_id  (w_rs2_id),
        .i_wr_en   (w_in_wb & w_reg_wr_en),
        .i_wr_id   (w_rd_id),
        .i_wr_data (w_wb_data),
        .o_rs1_data(w_rs1_data),
        .o_rs2_data(w_rs2_data),
        .o_end_data(o_end_data)
    );

    ifu u_ifu (
        .i_sys_clk(i_sys_clk),
        .i_arst_n (i_arst_n),
        .i_pc_en  (w_in_wb),
        .i_jmp_en (w_jmp_en),
        .i_jmp_pc (w_jmp_pc),
        .o_pc     (w_pc)
    );

    idu u_idu (
        .i_sys_clk  (i_sys_clk),
        .i_arst_n   (i_arst_n),
        .i_load_en  (state_q == ST_DECODE),
        .i_inst     (i_rom_rd_data),
        .o_rs1_id   (w_rs1_id),
        .o_rs2_id   (w_rs2_id),
        .o_rd_id    (w_rd_id),
        .o_imm      (w_imm),
        .o_alu_op   (w_alu_op),
        .o_use_imm  (w_use_imm),
        .o_branch   (w_branch),
        .o_branch_ne(w_branch_ne),
        .o_jal      (w_jal),
        .o_mem_rd   (w_mem_rd),
        .o_mem_wr   (w_mem_wr),
        .o_reg_wr_en(w_reg_wr_en),
        .o_end      (w_end),
        .o_wb_src   (w_wb_src)
    );

    exu u_exu (
        .i_sys_clk  (i_sys_clk),
        .i_arst_n   (i_arst_n),
        .i_exe_en   (state_q == ST_EXECUTE),
        .i_pc       (w_pc),
        .i_rs1_data (w_rs1_data),
        .i_rs2_data (w_rs2_data),
        .i_imm      (w_imm),
        .i_alu_op   (w_alu_op),
        .i_use_imm  (w_use_imm),
        .i_branch   (w_branch),
        .i_branch_ne(w_branch_ne),
        .i_jal      (w_jal),
        .o_res      (w_exu_res),
        .o_jmp_en   (w_jmp_en),
        .o_jmp_pc   (w_jmp_pc)
    );

    // Store data comes straight from rs2, still addressed by the latched instruction
    lsu u_lsu (
        .i_sys_clk    (i_sys_clk),
        .i_arst_n     (i_arst_n),
        .i_mem_en     (state_q == ST_MEMORY),
        .i_mem_rd     (w_mem_rd),
        .i_mem_wr     (w_mem_wr),
        .i_addr       (w_exu_res),
        .i_wr_data    (w_rs2_data),
        .i_ram_rd_data(i_ram_rd_data),
        .o_ram_rd_en  (o_ram_rd_en),
        .o_ram_rd_addr(o_ram_rd_addr),
        .o_ram_wr_en  (o_ram_wr_en),
        .o_ram_wr_addr(o_ram_wr_addr),
        .o_ram_wr_data(o_ram_wr_data),
        .o_load_data  (w_load_data)
    );

endmodule

`default_nettype wire

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
    output logic o_clk
);

    // 100 ns period
    initial begin
        o_clk = 1'b0;
        forever #50 o_clk = ~o_clk;
    end

endmodule

`default_nettype wire

// ==== test/tb_cpu.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_cpu
    import cpu_pkg::*;
();

    localparam int    SEED_INIT   = 32'h5b6537d0;
    localparam int    TIMEOUT     = 2000;
    localparam int    ROM_DEPTH   = 64;
    localparam int    RAM_DEPTH   = 64;
    localparam int    MAX_BODY    = 32;
    localparam int    ROUNDS      = 4;
    localparam inst_t EBREAK_INST = 32'h0010_0073;

    localparam int K_LUI    = 0;
    localparam int K_ADDI   = 1;
    localparam int K_ADD    = 2;
    localparam int K_SUB    = 3;
    localparam int K_AND    = 4;
    localparam int K_OR     = 5;
    localparam int K_XOR    = 6;
    localparam int K_SLT    = 7;
    localparam int K_LW     = 8;
    localparam int K_SW     = 9;
    localparam int K_BEQ    = 10;
    localparam int K_BNE    = 11;
    localparam int K_JAL    = 12;
    localparam int K_EBREAK = 13;

    localparam int M_ARITH = 0;
    localparam int M_STORE = 1;
    localparam int M_LOAD  = 2;
    localparam int M_CTRL  = 3;
    localparam int M_X0    = 4;

    logic  clk;
    logic  arst_n;
    inst_t rom_rd_data;
    addr_t rom_rd_addr;
    word_t ram_rd_data;
    logic  ram_rd_en;
    addr_t ram_rd_addr;
    logic  ram_wr_en;
    addr_t ram_wr_addr;
    word_t ram_wr_data;
    logic  end_flag;
    word_t end_data;

    inst_t   rom [ROM_DEPTH];
    word_t   ram [RAM_DEPTH];
    word_t   ram_init [RAM_DEPTH];
    int      kind_a [ROM_DEPTH];
    reg_id_t rd_a [ROM_DEPTH];
    reg_id_t rs1_a [ROM_DEPTH];
    reg_id_t rs2_a [ROM_DEPTH];
    word_t   imm_a [ROM_DEPTH];
    int      prog_len;

    word_t m_regs [32];
    word_t m_ram [RAM_DEPTH];
    addr_t m_st_addr [$];
    word_t m_st_data [$];
    addr_t m_ld_addr [$];
    addr_t dut_st_addr [$];
    word_t dut_st_data [$];
    addr_t dut_ld_addr [$];

    int    seed;
    string cur_test;
    int    test_checks;
    int    test_errors;
    int    total_checks;
    int    total_errors;
    int    tests_run;
    int    tests_failed;

    tb_clk_gen u_clk_gen (
        .o_clk(clk)
    );

    cpu u_cpu (
        .i_sys_clk    (clk),
        .i_arst_n     (arst_n),
        .i_rom_rd_data(rom_rd_data),
        .o_rom_rd_addr(rom_rd_addr),
        .i_ram_rd_data(ram_rd_data),
        .o_ram_rd_en  (ram_rd_en),
        .o_ram_rd_addr(ram_rd_addr),
        .o_ram_wr_en  (ram_wr_en),
        .o_ram_wr_addr(ram_wr_addr),
        .o_ram_wr_data(ram_wr_data),
        .o_end_flag   (end_flag),
        .o_end_data   (end_data)
    );

    // Fetches past the ROM see EBREAK
    assign rom_rd_data = (rom_rd_addr < ROM_DEPTH * 4) ? rom[rom_rd_addr[7:2]] : EBREAK_INST;
    assign ram_rd_data = ram[ram_rd_addr[7:2]];

    always @(posedge clk) begin
        if (ram_wr_en) begin
            ram[ram_wr_addr[7:2]] <= ram_wr_data;
            dut_st_addr.push_back(ram_wr_addr);
            dut_st_data.push_back(ram_wr_data);
        end
        if (ram_rd_en) begin
            dut_ld_addr.push_back(ram_rd_addr);
        end
    end

    function automatic int rand_range(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic int pick_kind(input int mode);
        int r;
        r = rand_range(10);
        case (mode)
            M_STORE: return (r < 4) ? K_SW : rand_range(8);
            M_LOAD:  return (r < 3) ? K_SW : (r < 6) ? K_LW : rand_range(8);
            M_CTRL:  return (r < 2) ? K_BEQ : (r < 4) ? K_BNE : (r < 5) ? K_JAL : rand_range(8);
            default: return rand_range(8);
        endcase
    endfunction

    // RV32I encodings, written from the ISA formats
    function automatic inst_t encode(input int k, input reg_id_t rd, input reg_id_t rs1,
                                     input reg_id_t rs2, input word_t imm);
        case (k)
            K_LUI:  return {imm[31:12], rd, OPC_LUI};
            K_ADDI: return {imm[11:0], rs1, 3'b000, rd, OPC_OPIMM};
            K_ADD:  return {7'h00, rs2, rs1, 3'b000, rd, OPC_OP};
            K_SUB:  return {7'h20, rs2, rs1, 3'b000, rd, OPC_OP};
            K_AND:  return {7'h00, rs2, rs1, 3'b111, rd, OPC_OP};
            K_OR:   return {7'h00, rs2, rs1, 3'b110, rd, OPC_OP};
            K_XOR:  return {7'h00, rs2, rs1, 3'b100, rd, OPC_OP};
            K_SLT:  return {7'h00, rs2, rs1, 3'b010, rd, OPC_OP};
            K_LW:   return {imm[11:0], rs1, 3'b010, rd, OPC_LOAD};
            K_SW:   return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
            K_BEQ:  return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], OPC_BRANCH};
            K_BNE:  return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], OPC_BRANCH};
            K_JAL:  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
            default: return EBREAK_INST;
        endcase
    endfunction

    task automatic gen_program(input int mode);
        int body;
        int d;
        body = 16 + rand_range(MAX_BODY - 15);
        for (int i = 0; i < body; i++) begin
            kind_a[i] = pick_kind(mode);
            rd_a[i]   = reg_id_t'(rand_range(16));
            rs1_a[i]  = reg_id_t'(rand_range(16));
            rs2_a[i]  = reg_id_t'(rand_range(16));
            imm_a[i]  = $random(seed);
            if (mode == M_X0) begin
                if (rand_range(2) == 0) rd_a[i] = '0;
                if (rand_range(2) == 0) rs1_a[i] = '0;
            end
            case (kind_a[i])
                K_LUI:  imm_a[i] = {imm_a[i][31:12], 12'h000};
                K_ADDI: imm_a[i] = {{20{imm_a[i][11]}}, imm_a[i][11:0]};
                K_LW, K_SW: begin
                    // Base x0, so the offset is the byte address
                    rs1_a[i] = '0;
                    d = (mode == M_LOAD) ? rand_range(8) : rand_range(RAM_DEPTH);
                    imm_a[i] = word_t'(d * 4);
                    if (kind_a[i] == K_LW && rand_range(2) == 0) rd_a[i] = END_REG;
                end
                K_BEQ, K_BNE, K_JAL: begin
                    // Forward only, never past the EBREAK
                    d = 1 + rand_range(4);
                    if (i + d > body + 1) d = body + 1 - i;
                    imm_a[i] = word_t'(d * 4);
                    if (rand_range(3) == 0) rs2_a[i] = rs1_a[i];
                    if (kind_a[i] == K_JAL && rand_range(2) == 0) rd_a[i] = END_REG;
                end
                default: ;
            endcase
        end
        kind_a[body] = K_ADD;
        rd_a[body]   = END_REG;
        rs1_a[body]  = END_REG;
        rs2_a[body]  = (mode == M_X0) ? reg_id_t'(0) : reg_id_t'(rand_range(16));
        imm_a[body]  = '0;
        kind_a[body + 1] = K_EBREAK;
        rd_a[body + 1]   = '0;
        rs1_a[body + 1]  = '0;
        rs2_a[body + 1]  = '0;
        imm_a[body + 1]  = '0;
        prog_len = body + 2;
    endtask

    task automatic load_memories();
        for (int i = 0; i < ROM_DEPTH; i++) begin
            if (i < prog_len) begin
                rom[i] = encode(kind_a[i], rd_a[i], rs1_a[i], rs2_a[i], imm_a[i]);
            end else begin
                rom[i] = EBREAK_INST;
            end
        end
        for (int i = 0; i < RAM_DEPTH; i++) begin
            ram_init[i] = $random(seed);
            ram[i] = ram_init[i];
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        arst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
    endtask

    task automatic wait_end(output bit ok);
        int cycles;
        cycles = 0;
        while (end_flag !== 1'b1 && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        ok = (end_flag === 1'b1);
    endtask

    // Instruction set model on the generated fields
    task automatic run_model();
        int    pc_idx;
        int    next_idx;
        int    steps;
        bit    done;
        bit    wr;
        word_t a;
        word_t b;
        word_t res;
        word_t addr;
        for (int r = 0; r < 32; r++) m_regs[r] = '0;
        for (int i = 0; i < RAM_DEPTH; i++) m_ram[i] = ram_init[i];
        m_st_addr.delete();
        m_st_data.delete();
        m_ld_addr.delete();
        pc_idx = 0;
        steps = 0;
        done = 1'b0;
        while (!done && steps < 4 * ROM_DEPTH) begin
            a = m_regs[rs1_a[pc_idx]];
            b = m_regs[rs2_a[pc_idx]];
            addr = a + imm_a[pc_idx];
            next_idx = pc_idx + 1;
            wr = 1'b1;
            res = '0;
            case (kind_a[pc_idx])
                K_LUI:  res = imm_a[pc_idx];
                K_ADDI: res = a + imm_a[pc_idx];
                K_ADD:  res = a + b;
                K_SUB:  res = a - b;
                K_AND:  res = a & b;
                K_OR:   res = a | b;
                K_XOR:  res = a ^ b;
                K_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                K_LW: begin
                    res = m_ram[(addr >> 2) % RAM_DEPTH];
                    m_ld_addr.push_back(addr);
                end
                K_SW: begin
                    wr = 1'b0;
                    m_ram[(addr >> 2) % RAM_DEPTH] = b;
                    m_st_addr.push_back(addr);
                    m_st_data.push_back(b);
                end
                K_BEQ, K_BNE: begin
                    wr = 1'b0;
                    if ((a == b) == (kind_a[pc_idx] == K_BEQ)) begin
                        next_idx = pc_idx + int'(imm_a[pc_idx] >> 2);
                    end
                end
                K_JAL: begin
                    res = word_t'(pc_idx * 4 + 4);
                    next_idx = pc_idx + int'(imm_a[pc_idx] >> 2);
                end
                default: begin
                    wr = 1'b0;
                    done = 1'b1;
                end
            endcase
            if (wr && rd_a[pc_idx] != 5'd0) m_regs[rd_a[pc_idx]] = res;
            pc_idx = next_idx;
            steps++;
        end
    endtask

    task automatic check_word(input string what, input word_t exp, input word_t act);
        test_checks++;
        assert (act === exp) else begin
            $display("CHECK FAILED %s %s expected %h actual %h", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_idle();
        check_word("end flag", '0, word_t'(end_flag));
        check_word("ram write enable", '0, word_t'(ram_wr_en));
        check_word("rom address", 32'h0000_0000, rom_rd_addr);
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic finish_test();
        $display("%-14s %s  checks %0d  errors %0d", cur_test,
                 (test_errors == 0) ? "PASS" : "FAIL", test_checks, test_errors);
        tests_run++;
        if (test_errors != 0) tests_failed++;
        total_checks += test_checks;
        total_errors += test_errors;
    endtask

    task automatic check_reset();
        gen_program(M_ARITH);
        load_memories();
        @(posedge clk);
        #1;
        arst_n = 1'b0;
        for (int c = 0; c < 16; c++) begin
            @(posedge clk);
            #1;
            check_idle();
        end
        arst_n = 1'b1;
        check_idle();
        @(posedge clk);
        #1;
        check_idle();
    endtask

    task automatic run_program(input int mode);
        bit ok;
        gen_program(mode);
        load_memories();
        dut_st_addr.delete();
        dut_st_data.delete();
        dut_ld_addr.delete();
        apply_reset();
        wait_end(ok);
        run_model();
        assert (ok) else begin
            $display("ERROR %s: end flag did not rise within %0d cycles", cur_test, TIMEOUT);
            test_errors++;
        end
        if (ok) begin
            check_word("x10", m_regs[END_REG], end_data);
            check_word("store count", word_t'(m_st_addr.size()), word_t'(dut_st_addr.size()));
            for (int i = 0; i < m_st_addr.size() && i < dut_st_addr.size(); i++) begin
                check_word("store address", m_st_addr[i], dut_st_addr[i]);
                check_word("store data", m_st_data[i], dut_st_data[i]);
            end
            check_word("load count", word_t'(m_ld_addr.size()), word_t'(dut_ld_addr.size()));
            for (int i = 0; i < m_ld_addr.size() && i < dut_ld_addr.size(); i++) begin
                check_word("load address", m_ld_addr[i], dut_ld_addr[i]);
            end
        end
    endtask

    initial begin
        seed = SEED_INIT;
        arst_n = 1'b0;
        prog_len = 0;
        tests_run = 0;
        tests_failed = 0;
        total_checks = 0;
        total_errors = 0;
        for (int i = 0; i < ROM_DEPTH; i++) rom[i] = EBREAK_INST;
        for (int i = 0; i < RAM_DEPTH; i++) ram[i] = '0;

        start_test("reset_state");
        check_reset();
        finish_test();
        start_test("random_arith");
        repeat (ROUNDS) run_program(M_ARITH);
        finish_test();
        start_test("store_trace");
        repeat (ROUNDS) run_program(M_STORE);
        finish_test();
        start_test("load_store");
        repeat (ROUNDS) run_program(M_LOAD);
        finish_test();
        start_test("control_flow");
        repeat (ROUNDS) run_program(M_CTRL);
        finish_test();
        start_test("register_x0");
        repeat (ROUNDS) run_program(M_X0);
        finish_test();

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
src/cpu_pkg.sv
src/gpr.sv
src/ifu.sv
src/idu.sv
src/exu.sv
src/lsu.sv
src/cpu.sv
test/tb_clk_gen.sv
test/tb_cpu.sv
